/* source/alu_params.svh */
// ALU width and register map
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand, result and AXI data width
`define ALU_XLEN 64

// one bit per supported operation
`define ALU_CTRL_W 17

`define ALU_AXI_AW 6

// byte offsets of the host registers
`define ALU_REG_SRC1   6'h00
`define ALU_REG_SRC2   6'h08
`define ALU_REG_CMD    6'h10
`define ALU_REG_RESULT 6'h18
`define ALU_REG_STATUS 6'h20

// opcode field in the CMD word
`define ALU_OP_LSB 0
`define ALU_OP_MSB 4

`endif

/* source/alu_pkg.sv */
// ALU shared types
package alu_pkg;

	// opcodes, value equals the control vector bit
	typedef enum logic [4:0] {
		OP_ADD  = 5'd0,
		OP_SUB  = 5'd1,
		OP_SLT  = 5'd2,
		OP_SLTU = 5'd3,
		OP_AND  = 5'd4,
		OP_OR   = 5'd5,
		OP_XOR  = 5'd6,
		OP_SLL  = 5'd7,
		OP_SRL  = 5'd8,
		OP_SRA  = 5'd9,
		OP_LUI  = 5'd10,
		OP_MUL  = 5'd11,
		OP_DIV  = 5'd12,
		OP_REM  = 5'd13,
		OP_MULU = 5'd14,
		OP_DIVU = 5'd15,
		OP_REMU = 5'd16	// 17..31 illegal
	} alu_op_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

endpackage

/* source/alu_cmd_in.sv */
// ALU command write port
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_cmd_in import alu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   awvalid,
	input  logic [`ALU_AXI_AW-1:0] awaddr,
	input  logic                   wvalid,
	input  logic [`ALU_XLEN-1:0]   wdata,
	input  logic [`ALU_XLEN/8-1:0] wstrb,	// strobes ignored
	input  logic                   bready,
	output logic                   awready,
	output logic                   wready,
	output logic                   bvalid,
	output axil_resp_e             bresp,
	output logic                   op_valid,
	output logic [`ALU_CTRL_W-1:0] alu_control,
	output logic [`ALU_XLEN-1:0]   src1,
	output logic [`ALU_XLEN-1:0]   src2
);

	logic                   wr_take;
	logic                   hit_src1;
	logic                   hit_src2;
	logic                   hit_cmd;
	logic                   wr_ok;
	logic                   launch;
	alu_op_e                cmd_op;
	logic                   cmd_legal;
	logic [`ALU_CTRL_W-1:0] ctrl_dec;

	// no new write while a response is pending
	assign wr_take = awvalid & wvalid & ~bvalid;
	assign awready = wr_take;
	assign wready  = wr_take;

	assign hit_src1 = (awaddr == `ALU_REG_SRC1);
	assign hit_src2 = (awaddr == `ALU_REG_SRC2);
	assign hit_cmd  = (awaddr == `ALU_REG_CMD);

	assign cmd_op    = alu_op_e'(wdata[`ALU_OP_MSB:`ALU_OP_LSB]);
	assign cmd_legal = (cmd_op <= OP_REMU);
	assign ctrl_dec  = {{(`ALU_CTRL_W-1){1'b0}}, 1'b1} << cmd_op;

	assign wr_ok  = hit_src1 | hit_src2 | (hit_cmd & cmd_legal);
	assign launch = wr_take & hit_cmd & cmd_legal;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
		end else if (wr_take) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// held until the next accepted write
	always_ff @(posedge clk) begin
		if (wr_take) begin
			if (wr_ok) begin
				bresp <= RESP_OKAY;
			end else begin
				bresp <= RESP_SLVERR;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src1 <= '0;
			src2 <= '0;
		end else if (wr_take) begin
			if (hit_src1) begin
				src1 <= wdata;
			end
			if (hit_src2) begin
				src2 <= wdata;
			end
		end
	end

	// launch pulse lines up with bvalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_valid    <= 1'b0;
			alu_control <= '0;
		end else begin
			op_valid <= launch;
			if (launch) begin
				alu_control <= ctrl_dec;
			end
		end
	end

endmodule

/* source/alu_core.sv */
// 64-bit ALU datapath
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_core import alu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   op_valid,
	input  logic [`ALU_CTRL_W-1:0] alu_control,
	input  logic [`ALU_XLEN-1:0]   src1,
	input  logic [`ALU_XLEN-1:0]   src2,
	output logic                   res_valid,
	output logic [`ALU_XLEN-1:0]   result
);

	localparam logic [`ALU_XLEN-1:0] XLEN_MIN = {1'b1, {(`ALU_XLEN-1){1'b0}}};

	logic                        adder_inv;
	logic [`ALU_XLEN-1:0]        adder_b;
	logic [`ALU_XLEN-1:0]        adder_sum;
	logic                        adder_cout;
	logic                        slt_bit;
	logic [`ALU_XLEN-1:0]        sra_result;
	logic                        div_zero;
	logic                        div_ovf;
	logic signed [`ALU_XLEN-1:0] sdiv_q;
	logic signed [`ALU_XLEN-1:0] srem_r;
	logic [`ALU_XLEN-1:0]        div_result;
	logic [`ALU_XLEN-1:0]        rem_result;
	logic [`ALU_XLEN-1:0]        divu_result;
	logic [`ALU_XLEN-1:0]        remu_result;
	logic [`ALU_XLEN-1:0]        alu_result;

	// sub and compares share the adder as a + ~b + 1
	assign adder_inv = alu_control[OP_SUB] | alu_control[OP_SLT] | alu_control[OP_SLTU];
	assign adder_b   = adder_inv ? ~src2 : src2;
	assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {{`ALU_XLEN{1'b0}}, adder_inv};

	// sign differs: src1 negative wins, else sign of the difference
	assign slt_bit = (src1[`ALU_XLEN-1] & ~src2[`ALU_XLEN-1])
		| (~(src1[`ALU_XLEN-1] ^ src2[`ALU_XLEN-1]) & adder_sum[`ALU_XLEN-1]);

	assign sra_result = $signed(src1) >>> src2[5:0];	// sign-filled right shift

	assign div_zero = (src2 == '0);
	assign div_ovf  = (src1 == XLEN_MIN) & (&src2);	// min / -1

	assign sdiv_q = $signed(src1) / $signed(src2);
	assign srem_r = $signed(src1) % $signed(src2);

	assign div_result  = div_zero ? '1 : (div_ovf ? src1 : sdiv_q);
	assign rem_result  = div_zero ? src1 : (div_ovf ? '0 : srem_r);
	assign divu_result = div_zero ? '1 : src1 / src2;
	assign remu_result = div_zero ? src1 : src1 % src2;

	// one-hot and-or select
	assign alu_result =
		  ({`ALU_XLEN{alu_control[OP_ADD] | alu_control[OP_SUB]}} & adder_sum)
		| ({`ALU_XLEN{alu_control[OP_SLT]}}  & {{(`ALU_XLEN-1){1'b0}}, slt_bit})
		| ({`ALU_XLEN{alu_control[OP_SLTU]}} & {{(`ALU_XLEN-1){1'b0}}, ~adder_cout})
		| ({`ALU_XLEN{alu_control[OP_AND]}}  & (src1 & src2))
		| ({`ALU_XLEN{alu_control[OP_OR]}}   & (src1 | src2))
		| ({`ALU_XLEN{alu_control[OP_XOR]}}  & (src1 ^ src2))
		| ({`ALU_XLEN{alu_control[OP_SLL]}}  & (src1 << src2[5:0]))
		| ({`ALU_XLEN{alu_control[OP_SRL]}}  & (src1 >> src2[5:0]))
		| ({`ALU_XLEN{alu_control[OP_SRA]}}  & sra_result)
		| ({`ALU_XLEN{alu_control[OP_LUI]}}  & src2)
		| ({`ALU_XLEN{alu_control[OP_MUL]}}  & ($signed(src1) * $signed(src2)))
		| ({`ALU_XLEN{alu_control[OP_DIV]}}  & div_result)
		| ({`ALU_XLEN{alu_control[OP_REM]}}  & rem_result)
		| ({`ALU_XLEN{alu_control[OP_MULU]}} & (src1 * src2))
		| ({`ALU_XLEN{alu_control[OP_DIVU]}} & divu_result)
		| ({`ALU_XLEN{alu_control[OP_REMU]}} & remu_result);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= op_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (op_valid) begin
			result <= alu_result;
		end
	end

endmodule

/* source/alu_result_out.sv */
// ALU result read port
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_result_out import alu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   res_valid,
	input  logic [`ALU_XLEN-1:0]   result,
	input  logic                   op_valid,
	input  logic                   arvalid,
	input  logic [`ALU_AXI_AW-1:0] araddr,
	input  logic                   rready,
	output logic                   arready,
	output logic                   rvalid,
	output logic [`ALU_XLEN-1:0]   rdata,
	output axil_resp_e             rresp
);

	logic [`ALU_XLEN-1:0] result_q;
	logic                 done;
	logic                 rd_take;
	logic                 rd_hit;
	logic [`ALU_XLEN-1:0] rd_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_q <= '0;
			done     <= 1'b0;
		end else begin
			if (res_valid) begin
				result_q <= result;
			end
			if (op_valid) begin
				done <= 1'b0;	// new launch
			end else if (res_valid) begin
				done <= 1'b1;
			end
		end
	end

	assign rd_take = arvalid & ~rvalid;
	assign arready = rd_take;

	always_comb begin
		rd_data = '0;
		rd_hit  = 1'b1;
		case (araddr)
			`ALU_REG_RESULT: rd_data = result_q;
			`ALU_REG_STATUS: rd_data = {{(`ALU_XLEN-1){1'b0}}, done};
			default:         rd_hit  = 1'b0;	// unmapped reads zero
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_take) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_take) begin
			rdata <= rd_data;
			rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

/* source/alu_axil_top.sv */
// AXI4-Lite ALU top
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_axil_top import alu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	// write side
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [`ALU_AXI_AW-1:0] awaddr,
	input  logic                   wvalid,
	output logic                   wready,
	input  logic [`ALU_XLEN-1:0]   wdata,
	input  logic [`ALU_XLEN/8-1:0] wstrb,
	output logic                   bvalid,
	input  logic                   bready,
	output axil_resp_e             bresp,
	// read side
	input  logic                   arvalid,
	output logic                   arready,
	input  logic [`ALU_AXI_AW-1:0] araddr,
	output logic                   rvalid,
	input  logic                   rready,
	output logic [`ALU_XLEN-1:0]   rdata,
	output axil_resp_e             rresp
);

	logic                   op_valid;
	logic [`ALU_CTRL_W-1:0] alu_control;
	logic [`ALU_XLEN-1:0]   src1;
	logic [`ALU_XLEN-1:0]   src2;
	logic                   res_valid;
	logic [`ALU_XLEN-1:0]   result;

	alu_cmd_in u_cmd_in (
		.clk, .rst_n,
		.awvalid, .awaddr, .wvalid, .wdata, .wstrb, .bready,
		.awready, .wready, .bvalid, .bresp,
		.op_valid, .alu_control, .src1, .src2
	);

	alu_core u_core (
		.clk, .rst_n,
		.op_valid, .alu_control, .src1, .src2,
		.res_valid, .result
	);

	// op_valid also clears done
	alu_result_out u_result_out (
		.clk, .rst_n,
		.res_valid, .result, .op_valid,
		.arvalid, .araddr, .rready,
		.arready, .rvalid, .rdata, .rresp
	);

endmodule

/* verif/alu_chk.sv */
// ALU protocol checks
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_chk import alu_pkg::*; (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 awready,
	input logic                 wready,
	input logic                 bvalid,
	input logic                 bready,
	input axil_resp_e           bresp,
	input logic                 rvalid,
	input logic                 rready,
	input logic [`ALU_XLEN-1:0] rdata,
	input axil_resp_e           rresp,
	input logic                 op_valid,
	input logic                 res_valid
);

	int unsigned fail_count = 0;	// failed assertions so far

	aw_w_together: assert property (@(posedge clk) disable iff (!rst_n)
		awready == wready)
		else begin
			$error("awready and wready differ");
			fail_count++;
		end

	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("write response changed before bready");
			fail_count++;
		end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("read response changed before rready");
			fail_count++;
		end

	// core latency is one cycle
	res_latency: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid == $past(op_valid))
		else begin
			$error("res_valid does not follow op_valid by one cycle");
			fail_count++;
		end

endmodule

/* verif/alu_tb.sv */
// AXI4-Lite ALU testbench
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_tb import alu_pkg::*; ();

	localparam logic [`ALU_XLEN-1:0] ONES = '1;
	localparam logic [`ALU_XLEN-1:0] MIN  = 64'h8000_0000_0000_0000;

	typedef struct {
		alu_op_e              op;
		logic [`ALU_XLEN-1:0] a;
		logic [`ALU_XLEN-1:0] b;
		logic [`ALU_XLEN-1:0] exp;
		axil_resp_e           resp;
	} entry_t;

	logic                   clk;
	logic                   rst_n;
	logic                   awvalid;
	logic                   awready;
	logic [`ALU_AXI_AW-1:0] awaddr;
	logic                   wvalid;
	logic                   wready;
	logic [`ALU_XLEN-1:0]   wdata;
	logic [`ALU_XLEN/8-1:0] wstrb;
	logic                   bvalid;
	logic                   bready;
	axil_resp_e             bresp;
	logic                   arvalid;
	logic                   arready;
	logic [`ALU_AXI_AW-1:0] araddr;
	logic                   rvalid;
	logic                   rready;
	logic [`ALU_XLEN-1:0]   rdata;
	axil_resp_e             rresp;
	entry_t                 table_q[$];
	integer                 seed = 48;

	alu_axil_top DUT (.*);

	bind alu_axil_top alu_chk u_chk (
		.clk(clk), .rst_n(rst_n), .awready(awready), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.op_valid(op_valid), .res_valid(res_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	// protocol assertions in the bound checker
	always @(DUT.u_chk.fail_count) begin
		if (DUT.u_chk.fail_count != 0) begin
			abort_run("A protocol assertion in the bound checker failed.");
		end
	end

	task automatic check_data(input string name, input logic [`ALU_XLEN-1:0] act,
			input logic [`ALU_XLEN-1:0] exp);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp));
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e act, input axil_resp_e exp);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp));
		end
	endtask

	function automatic logic flag_high(input string name);
		case (name)
			"awready": return awready;
			"bvalid":  return bvalid;
			"arready": return arready;
			default:   return rvalid;
		endcase
	endfunction

	// sampled mid-cycle, away from the edges
	task automatic wait_for(input string name);
		int n;
		n = 0;
		@(negedge clk);
		while (!flag_high(name)) begin
			n++;
			if (n > 50) abort_run({"Timed out waiting for ", name, " to go high."});
			@(negedge clk);
		end
	endtask

	task automatic axil_write(input logic [`ALU_AXI_AW-1:0] addr,
			input logic [`ALU_XLEN-1:0] data, output axil_resp_e resp);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		wait_for("awready");
		@(posedge clk);
		#10;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		wait_for("bvalid");
		resp = bresp;
		@(posedge clk);
		#10;
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [`ALU_AXI_AW-1:0] addr,
			output logic [`ALU_XLEN-1:0] data, output axil_resp_e resp);
		araddr  = addr;
		arvalid = 1'b1;
		wait_for("arready");
		@(posedge clk);
		#10;
		arvalid = 1'b0;
		rready  = 1'b1;
		wait_for("rvalid");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#10;
		rready = 1'b0;
	endtask

	task automatic poll_done();
		logic [`ALU_XLEN-1:0] d;
		axil_resp_e           r;
		int                   n;
		d = '0;
		n = 0;
		while (!d[0]) begin
			if (n == 50) abort_run("STATUS done bit did not rise within 50 polls.");
			axil_read(`ALU_REG_STATUS, d, r);
			check_resp("rresp", r, RESP_OKAY);
			n++;
		end
	endtask

	task automatic run_op(input alu_op_e op, input logic [`ALU_XLEN-1:0] a,
			input logic [`ALU_XLEN-1:0] b, input logic [`ALU_XLEN-1:0] exp,
			input axil_resp_e exp_resp);
		logic [`ALU_XLEN-1:0] d;
		axil_resp_e           r;
		axil_write(`ALU_REG_SRC1, a, r);
		check_resp("bresp", r, RESP_OKAY);
		axil_write(`ALU_REG_SRC2, b, r);
		check_resp("bresp", r, RESP_OKAY);
		axil_write(`ALU_REG_CMD, {{(`ALU_XLEN-5){1'b0}}, op}, r);
		check_resp("bresp", r, exp_resp);
		if (exp_resp == RESP_OKAY) begin
			poll_done();
		end else begin
			axil_read(`ALU_REG_STATUS, d, r);	// done from the last launch
			check_resp("rresp", r, RESP_OKAY);
			check_data("STATUS", d, 64'h1);
		end
		axil_read(`ALU_REG_RESULT, d, r);
		check_resp("rresp", r, RESP_OKAY);
		check_data("RESULT", d, exp);
	endtask

	function automatic void add_entry(input alu_op_e op, input logic [`ALU_XLEN-1:0] a,
			input logic [`ALU_XLEN-1:0] b, input logic [`ALU_XLEN-1:0] exp,
			input axil_resp_e resp);
		table_q.push_back('{op, a, b, exp, resp});
	endfunction

	function automatic void build_table();
		add_entry(OP_ADD, 64'd5, 64'd7, 64'd12, RESP_OKAY);
		add_entry(OP_ADD, ONES, 64'd1, 64'd0, RESP_OKAY);
		add_entry(OP_SUB, 64'd3, 64'd5, 64'hffff_ffff_ffff_fffe, RESP_OKAY);
		add_entry(OP_SLT, ONES, 64'd1, 64'd1, RESP_OKAY);
		add_entry(OP_SLTU, ONES, 64'd1, 64'd0, RESP_OKAY);
		add_entry(OP_SLT, 64'd1, ONES, 64'd0, RESP_OKAY);
		add_entry(OP_SLTU, 64'd1, ONES, 64'd1, RESP_OKAY);
		add_entry(OP_SLT, MIN, 64'h7fff_ffff_ffff_ffff, 64'd1, RESP_OKAY);
		add_entry(OP_SLT, 64'd3, 64'd5, 64'd1, RESP_OKAY);	// same sign
		add_entry(OP_AND, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
			64'hf000_f000_f000_f000, RESP_OKAY);
		add_entry(OP_OR, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
			64'hfff0_fff0_fff0_fff0, RESP_OKAY);
		add_entry(OP_XOR, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
			64'h0ff0_0ff0_0ff0_0ff0, RESP_OKAY);
		add_entry(OP_SLL, 64'd1, 64'd63, MIN, RESP_OKAY);
		add_entry(OP_SLL, 64'd3, 64'h41, 64'd6, RESP_OKAY);	// only low 6 bits count
		add_entry(OP_SRL, MIN, 64'd4, 64'h0800_0000_0000_0000, RESP_OKAY);
		add_entry(OP_SRA, MIN, 64'd4, 64'hf800_0000_0000_0000, RESP_OKAY);
		add_entry(OP_LUI, 64'h1234, 64'habcd_e000, 64'habcd_e000, RESP_OKAY);
		add_entry(OP_MUL, 64'hffff_ffff_ffff_fffd, 64'd7, 64'hffff_ffff_ffff_ffeb, RESP_OKAY);
		add_entry(OP_MULU, 64'h1_0000_0000, 64'h1_0000_0001, 64'h1_0000_0000, RESP_OKAY);
		add_entry(OP_DIV, 64'hffff_ffff_ffff_ffec, 64'd3, 64'hffff_ffff_ffff_fffa, RESP_OKAY);
		add_entry(OP_REM, 64'hffff_ffff_ffff_ffec, 64'd3, 64'hffff_ffff_ffff_fffe, RESP_OKAY);
		add_entry(OP_DIVU, 64'd100, 64'd7, 64'd14, RESP_OKAY);
		add_entry(OP_REMU, 64'd100, 64'd7, 64'd2, RESP_OKAY);
		add_entry(alu_op_e'(5'd20), 64'd5, 64'd6, 64'd2, RESP_SLVERR);	// result kept
		add_entry(OP_DIV, 64'h1234, 64'd0, ONES, RESP_OKAY);
		add_entry(OP_DIVU, 64'h1234, 64'd0, ONES, RESP_OKAY);
		add_entry(OP_REM, 64'h1234, 64'd0, 64'h1234, RESP_OKAY);
		add_entry(OP_REMU, 64'h1234, 64'd0, 64'h1234, RESP_OKAY);
		add_entry(OP_DIV, MIN, ONES, MIN, RESP_OKAY);
		add_entry(OP_REM, MIN, ONES, 64'd0, RESP_OKAY);
		add_entry(OP_DIVU, ONES, 64'd2, 64'h7fff_ffff_ffff_ffff, RESP_OKAY);
	endfunction

	initial begin
		logic [`ALU_XLEN-1:0] d;
		logic [`ALU_XLEN-1:0] a;
		logic [`ALU_XLEN-1:0] b;
		axil_resp_e           r;
		rst_n   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '1;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		build_table();
		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;

		axil_read(`ALU_REG_STATUS, d, r);
		check_resp("rresp", r, RESP_OKAY);
		check_data("STATUS", d, 64'd0);
		axil_read(`ALU_REG_RESULT, d, r);
		check_resp("rresp", r, RESP_OKAY);
		check_data("RESULT", d, 64'd0);

		foreach (table_q[i]) begin
			run_op(table_q[i].op, table_q[i].a, table_q[i].b, table_q[i].exp, table_q[i].resp);
		end

		for (int i = 0; i < 12; i++) begin
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			case (i % 3)
				0:       run_op(OP_ADD, a, b, a + b, RESP_OKAY);
				1:       run_op(OP_XOR, a, b, a ^ b, RESP_OKAY);
				default: run_op(OP_SLL, a, b, a << b[5:0], RESP_OKAY);
			endcase
		end

		// unmapped and read-only offsets
		axil_write(6'h28, 64'h55, r);
		check_resp("bresp", r, RESP_SLVERR);
		axil_write(`ALU_REG_RESULT, 64'h55, r);
		check_resp("bresp", r, RESP_SLVERR);
		axil_read(6'h28, d, r);
		check_resp("rresp", r, RESP_SLVERR);
		check_data("rdata", d, 64'd0);

		// second write stalls behind a pending response
		awaddr  = `ALU_REG_SRC1;
		wdata   = 64'h1111;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		wait_for("awready");
		@(posedge clk);
		#10;
		awaddr = `ALU_REG_SRC2;
		wdata  = 64'h2222;
		repeat (4) begin
			@(negedge clk);
			if (!bvalid || awready) abort_run("A write was taken while bvalid was pending.");
			check_resp("bresp", bresp, RESP_OKAY);
		end
		@(posedge clk);
		#10;
		bready = 1'b1;
		wait_for("awready");
		@(posedge clk);
		#10;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		wait_for("bvalid");
		check_resp("bresp", bresp, RESP_OKAY);
		@(posedge clk);
		#10;
		bready = 1'b0;
		axil_write(`ALU_REG_CMD, {{(`ALU_XLEN-5){1'b0}}, OP_ADD}, r);
		check_resp("bresp", r, RESP_OKAY);
		poll_done();

		araddr  = `ALU_REG_RESULT;
		arvalid = 1'b1;
		wait_for("arready");
		@(posedge clk);
		#10;
		arvalid = 1'b0;
		repeat (4) begin
			@(negedge clk);
			if (!rvalid) abort_run("rvalid dropped while rready was low.");
			check_data("rdata", rdata, 64'h3333);
			check_resp("rresp", rresp, RESP_OKAY);
		end
		@(posedge clk);
		#10;
		rready = 1'b1;
		@(posedge clk);
		#10;
		rready = 1'b0;

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* list.f */
+incdir+source
source/alu_pkg.sv
source/alu_cmd_in.sv
source/alu_core.sv
source/alu_result_out.sv
source/alu_axil_top.sv
verif/alu_chk.sv
verif/alu_tb.sv

/* Bender.yml */
package:
  name: alu_axil

sources:
  - include_dirs:
      - source
    files:
      - source/alu_pkg.sv
      - source/alu_cmd_in.sv
      - source/alu_core.sv
      - source/alu_result_out.sv
      - source/alu_axil_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/alu_chk.sv
      - verif/alu_tb.sv
